/* Makefile */
VERILATOR   ?= verilator
TOP         := tb_tx_arbiter
FILELIST    := project.f
OBJ_DIR     := obj_dir
BUILD_FLAGS := --binary --timing --assert --timescale 1ns/10ps -Wno-fatal -j 0
LINT_FLAGS  := --lint-only --timing -Wall --timescale 1ns/10ps
PASS_MSG    := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* hw/arb_pkg.sv */
// Arbiter package with channel codes, request and throttle sets and the queue depth
package arb_pkg;

  // Channel select code driven to the transmit pipeline mux
  typedef enum logic [1:0] {
    CFG = 2'd0, // Config channel
    CC  = 2'd1, // Completions
    RW  = 2'd2, // Requester writes
    RR  = 2'd3  // Requester reads
  } chan_sel_e;

  // One bit per channel, MSB first
  // Used by the PSR, by the FIFO entries and by the new request vector
  typedef struct packed {
    logic rw;  // Bit 3, highest priority
    logic cc;  // Bit 2
    logic cfg; // Bit 1
    logic rr;  // Bit 0, lowest priority
  } req_set_t;

  // Hold-back flags to the user channels
  // CFG never gets throttled
  typedef struct packed {
    logic rw;
    logic cc;
    logic rr;
  } thrtl_t;

  // Pending request queue depth
  // One slot stays unused, so 4 holds the 3 requests that can
  // pile up while a fourth channel is being served
  localparam int DEF_FIFO_DEPTH = 4;

endpackage

/* hw/pkt_scheduler.sv */
// Packet scheduler, holds the PSR, picks the channel, tracks completion and throttles
`timescale 1ns/10ps

module pkt_scheduler (
  input  logic                    com_iclk,
  input  logic                    com_sysrst,
  input  stream_pkg::chan_beats_t chan_beats,
  input  logic                    tx_ready,     // Downstream ready
  input  logic                    link_up,
  input  arb_pkg::req_set_t       pkt_req,      // From the detector
  input  arb_pkg::req_set_t       fifo_head,
  input  logic                    fifo_empty,
  output logic                    completed,    // One cycle after the accepted last beat
  output logic                    psr_idle,
  output arb_pkg::chan_sel_e      channel_sel,
  output logic                    push,
  output arb_pkg::req_set_t       push_data,
  output logic                    pop,
  output arb_pkg::thrtl_t         thrtl
);

  import arb_pkg::*;
  import stream_pkg::*;

  req_set_t psr;           // Packet status register
  req_set_t psr_nxt;
  req_set_t served;        // Bit of the channel being served
  beat_t    sel_beat;      // Sideband of the selected channel
  logic     psr_single;    // Exactly one request left
  logic     psr_multi;     // More than one left
  logic     has_req;
  logic     any_valid;
  logic     more_pending;  // Others still wait after this one

  assign psr_idle     = (psr == '0);
  assign psr_single   = $onehot(psr);
  assign psr_multi    = !$onehot0(psr);
  assign has_req      = (pkt_req != '0);
  assign any_valid    = chan_beats.rw.valid | chan_beats.cc.valid |
                        chan_beats.cfg.valid | chan_beats.rr.valid;
  assign more_pending = !fifo_empty || psr_multi;
  assign push_data    = pkt_req;  // Only the new requests get queued

  // Fixed priority RW, CC, CFG, RR
  always_comb begin
    if (psr.rw) begin
      channel_sel = RW;
    end else if (psr.cc) begin
      channel_sel = CC;
    end else if (psr.cfg) begin
      channel_sel = CFG;
    end else if (psr.rr) begin
      channel_sel = RR;
    end else begin
      channel_sel = RW;  // Idle default, lets a lone RW packet start at once
    end
  end

  always_comb begin
    served = '0;
    case (channel_sel)
      RW: begin
        sel_beat  = chan_beats.rw;
        served.rw = 1'b1;
      end
      CC: begin
        sel_beat  = chan_beats.cc;
        served.cc = 1'b1;
      end
      CFG: begin
        sel_beat   = chan_beats.cfg;
        served.cfg = 1'b1;
      end
      default: begin
        sel_beat  = chan_beats.rr;
        served.rr = 1'b1;
      end
    endcase
  end

  // Accepted last beat on the selected channel
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      completed <= 1'b0;
    end else begin
      completed <= sel_beat.valid & sel_beat.last & tx_ready;
    end
  end

  // Next PSR and FIFO control
  always_comb begin
    psr_nxt = psr;
    push    = 1'b0;
    pop     = 1'b0;
    if (fifo_empty) begin
      if (psr_idle) begin
        if (has_req) begin
          psr_nxt = pkt_req;  // Straight in, nothing ahead
        end
      end else if (completed && psr_single) begin
        psr_nxt = pkt_req;  // Last one served, take whatever is new
      end else if (completed) begin
        psr_nxt = link_up ? (psr & ~served) : '0;
        push    = has_req;
      end else if (has_req) begin
        push = 1'b1;  // Busy, queue it
      end else if (!link_up && !any_valid) begin
        psr_nxt = '0;  // Nothing left to send on a dead link
      end
    end else begin
      if (completed && psr_single) begin
        psr_nxt = fifo_head;
        pop     = 1'b1;
      end else if (completed) begin
        psr_nxt = psr & ~served;
      end
      push = has_req;  // Queue behind older entries
    end
  end

  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      psr <= '0;
    end else begin
      psr <= psr_nxt;
    end
  end

  // Channel just served wants another packet but others come first
  always_comb begin
    thrtl.rw = completed && (channel_sel == RW) && pkt_req.rw && more_pending;
    thrtl.cc = completed && (channel_sel == CC) && pkt_req.cc && more_pending;
    thrtl.rr = completed && (channel_sel == RR) && pkt_req.rr && more_pending;
  end

endmodule

/* hw/req_detect.sv */
// Request detector, turns valid edges and back-to-back valids into packet requests
`timescale 1ns/10ps

module req_detect (
  input  logic                    com_iclk,
  input  logic                    com_sysrst,
  input  stream_pkg::chan_beats_t chan_beats,  // User sideband of all channels
  input  logic                    link_up,
  input  logic                    completed,   // Served packet finished last cycle
  input  arb_pkg::chan_sel_e      channel_sel,
  input  logic                    psr_idle,    // Nothing being served
  output arb_pkg::req_set_t       pkt_req      // New requests this cycle
);

  import arb_pkg::*;

  req_set_t valid_now;   // Live valids gathered as a request set
  req_set_t valid_q;     // Valids of the last cycle
  req_set_t valid_rise;  // Rising edges
  req_set_t b2b;         // Valid kept high right after own completion
  logic     link_up_q;
  logic     link_rise;
  logic     cc_in_pkt;   // CC packet running, masks new CC requests

  always_comb begin
    valid_now.rw  = chan_beats.rw.valid;
    valid_now.cc  = chan_beats.cc.valid;
    valid_now.cfg = chan_beats.cfg.valid;
    valid_now.rr  = chan_beats.rr.valid;
  end

  assign valid_rise = valid_now & ~valid_q;
  assign link_rise  = link_up & ~link_up_q;

  // Edge registers
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      valid_q   <= '0;
      link_up_q <= 1'b0;
    end else begin
      valid_q   <= valid_now;
      link_up_q <= link_up;
    end
  end

  // CC tracking, set on a non-final beat and cleared by last
  // A dead link drops any packet in flight
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      cc_in_pkt <= 1'b0;
    end else if (!link_up) begin
      cc_in_pkt <= 1'b0;
    end else if (chan_beats.cc.valid && !chan_beats.cc.last) begin
      cc_in_pkt <= 1'b1;
    end else if (chan_beats.cc.last) begin
      cc_in_pkt <= 1'b0;
    end
  end

  // Valid never dropped between packets so no edge shows
  // Only the channel just served can ask this way
  always_comb begin
    b2b = '0;
    if (completed) begin
      case (channel_sel)
        RW:  b2b.rw  = valid_now.rw;
        CC:  b2b.cc  = valid_now.cc;
        CFG: b2b.cfg = valid_now.cfg;
        RR:  b2b.rr  = valid_now.rr;
      endcase
    end
  end

  always_comb begin
    pkt_req.rw  = valid_rise.rw | b2b.rw;
    pkt_req.cc  = !cc_in_pkt && (valid_rise.cc || b2b.cc);  // Masked mid-packet
    // CFG request lost on link down gets raised again on link up
    pkt_req.cfg = valid_rise.cfg | b2b.cfg | (link_rise & valid_now.cfg & psr_idle);
    pkt_req.rr  = valid_rise.rr | b2b.rr;
  end

endmodule

/* hw/req_fifo.sv */
// Request FIFO, circular queue of pending request sets, flushed when the link drops
`timescale 1ns/10ps

module req_fifo #(
  parameter int DEPTH = arb_pkg::DEF_FIFO_DEPTH
) (
  input  logic              com_iclk,
  input  logic              com_sysrst,
  input  logic              flush,      // Link lost
  input  logic              push,
  input  arb_pkg::req_set_t push_data,
  input  logic              pop,
  output arb_pkg::req_set_t head,       // Oldest entry
  output logic              empty
);

  import arb_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  req_set_t      mem [DEPTH];  // Entry storage
  logic [AW-1:0] rd_ptr;
  logic [AW-1:0] wr_ptr;

  // Wraps at DEPTH, so any depth works, not just powers of two
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    logic [AW-1:0] nxt;
    nxt = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  // Pointers equal means empty, so one slot is never filled
  assign empty = (rd_ptr == wr_ptr);
  assign head  = mem[rd_ptr];  // Shows a push one edge later

  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
    end else if (flush) begin
      rd_ptr <= '0;  // Drop everything queued
      wr_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
    end
  end

  always_ff @(posedge com_iclk) begin
    if (push && !flush) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

/* hw/stream_pkg.sv */
// Stream package with the per-channel valid and last sideband of the user interfaces
package stream_pkg;

  // Sideband of one user channel, only what the arbiter looks at
  typedef struct packed {
    logic valid; // Beat presented
    logic last;  // Final beat of the packet
  } beat_t;

  // All four channels side by side
  // Same channel order as the request set
  typedef struct packed {
    beat_t rw;  // Requester write port
    beat_t cc;  // Completion port
    beat_t cfg; // Config port
    beat_t rr;  // Requester read port
  } chan_beats_t;

endpackage

/* hw/tx_arbiter_top.sv */
// Transmit arbiter top, joins request detection, request FIFO and packet scheduler
`timescale 1ns/10ps

module tx_arbiter_top #(
  parameter int FIFO_DEPTH = arb_pkg::DEF_FIFO_DEPTH
) (
  input  logic                    com_iclk,
  input  logic                    com_sysrst,
  input  stream_pkg::chan_beats_t chan_beats,
  input  logic                    tx_ready,
  input  logic                    link_up,
  output arb_pkg::chan_sel_e      channel_sel,
  output arb_pkg::thrtl_t         thrtl
);

  import arb_pkg::*;

  req_set_t pkt_req;     // Detector to scheduler
  req_set_t push_data;
  req_set_t fifo_head;
  logic     completed;
  logic     psr_idle;
  logic     push;
  logic     pop;
  logic     fifo_empty;

  req_detect u_req_detect (
    .com_iclk    (com_iclk),
    .com_sysrst  (com_sysrst),
    .chan_beats  (chan_beats),
    .link_up     (link_up),
    .completed   (completed),
    .channel_sel (channel_sel),
    .psr_idle    (psr_idle),
    .pkt_req     (pkt_req)
  );

  req_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_req_fifo (
    .com_iclk   (com_iclk),
    .com_sysrst (com_sysrst),
    .flush      (!link_up),  // Queue dropped while the link is down
    .push       (push),
    .push_data  (push_data),
    .pop        (pop),
    .head       (fifo_head),
    .empty      (fifo_empty)
  );

  pkt_scheduler u_pkt_scheduler (
    .com_iclk    (com_iclk),
    .com_sysrst  (com_sysrst),
    .chan_beats  (chan_beats),
    .tx_ready    (tx_ready),
    .link_up     (link_up),
    .pkt_req     (pkt_req),
    .fifo_head   (fifo_head),
    .fifo_empty  (fifo_empty),
    .completed   (completed),
    .psr_idle    (psr_idle),
    .channel_sel (channel_sel),
    .push        (push),
    .push_data   (push_data),
    .pop         (pop),
    .thrtl       (thrtl)
  );

endmodule

/* project.f */
hw/arb_pkg.sv
hw/stream_pkg.sv
hw/req_detect.sv
hw/req_fifo.sv
hw/pkt_scheduler.sv
hw/tx_arbiter_top.sv
tb/tx_arbiter_properties.sv
tb/tb_tx_arbiter.sv

/* tb/tb_tx_arbiter.sv */
// Testbench for the transmit arbiter with directed runs over order, back-pressure, throttle and link loss
`timescale 1ns/10ps

module tb_tx_arbiter;

  import arb_pkg::*;
  import stream_pkg::*;

  localparam int MAX_CYCLES = 2000;  // Tests need about 130 cycles

  logic        com_iclk;
  logic        com_sysrst;
  chan_beats_t beats;        // Driven sideband of all four channels
  logic        tx_ready;
  logic        link_up;
  chan_sel_e   channel_sel;
  thrtl_t      thrtl;
  logic [31:0] lfsr_state;
  int          cycle_cnt = 0;

  tx_arbiter_top #(
    .FIFO_DEPTH (DEF_FIFO_DEPTH)
  ) DUT (
    .com_iclk    (com_iclk),
    .com_sysrst  (com_sysrst),
    .chan_beats  (beats),
    .tx_ready    (tx_ready),
    .link_up     (link_up),
    .channel_sel (channel_sel),
    .thrtl       (thrtl)
  );

  bind pkt_scheduler tx_arbiter_properties u_props (
    .com_iclk    (com_iclk),
    .com_sysrst  (com_sysrst),
    .tx_ready    (tx_ready),
    .link_up     (link_up),
    .completed   (completed),
    .psr_idle    (psr_idle),
    .channel_sel (channel_sel),
    .push        (push),
    .pop         (pop)
  );

  initial com_iclk = 1'b0;
  always #20 com_iclk = ~com_iclk;  // 40 ns period

  // Watchdog
  always @(posedge com_iclk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      fail_stop("Run hit the cycle limit, arbiter stuck");
    end
  end

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "Stopped at cycle %0d", cycle_cnt);
  endtask

  task automatic check_val(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
      fail_stop($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h (cycle %0d)",
                          name, actual, expected, cycle_cnt));
    end
  endtask

  task automatic expect_channel(input chan_sel_e exp);
    check_val("channel_sel", 32'(channel_sel), 32'(exp));
  endtask

  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // One LFSR step per bit
  function automatic int rand_bits(input int nbits);
    int val;
    val = 0;
    for (int i = 0; i < nbits; i++) begin
      val = (val << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
    return val;
  endfunction

  function automatic int pkt_len();
    return 1 + rand_bits(2);  // 1 to 4 beats
  endfunction

  // Lands 2 ns after the rising edge, where inputs change
  task automatic next_cycle();
    @(posedge com_iclk);
    #2;
  endtask

  task automatic drive_beat(input chan_sel_e ch, input logic v, input logic l);
    case (ch)
      RW:  beats.rw  = {v, l};
      CC:  beats.cc  = {v, l};
      CFG: beats.cfg = {v, l};
      RR:  beats.rr  = {v, l};
    endcase
  endtask

  // Beats on the granted channel with last on the final one
  // Ends in the completion cycle with valid set to hold_valid
  task automatic send_packet(input chan_sel_e ch, input int nbeats, input logic hold_valid);
    for (int i = 0; i < nbeats; i++) begin
      drive_beat(ch, 1'b1, i == nbeats - 1);
      next_cycle();
      expect_channel(ch);  // Grant holds through the packet and its completion cycle
    end
    drive_beat(ch, hold_valid, 1'b0);
  endtask

  task automatic wait_sel(input chan_sel_e exp, input int limit);
    int n;
    n = 0;
    while (channel_sel != exp) begin
      if (n == limit) begin
        fail_stop($sformatf("channel_sel never returned to %s", exp.name()));
      end
      next_cycle();
      n++;
    end
  endtask

  task automatic reset_state();
    expect_channel(RW);   // Idle default
    check_val("thrtl", 32'(thrtl), 32'(0));
  endtask

  task automatic single_request(input chan_sel_e ch);
    drive_beat(ch, 1'b1, 1'b0);  // Valid rises and the first beat waits for the grant
    next_cycle();
    expect_channel(ch);
    send_packet(ch, pkt_len(), 1'b0);
    next_cycle();
    expect_channel(RW);   // Two edges after the last beat
    check_val("thrtl", 32'(thrtl), 32'(0));
  endtask

  task automatic all_at_once();
    chan_sel_e order [4];
    chan_sel_e exp;
    order = '{RW, CC, CFG, RR};  // Fixed priority
    beats = '{rw: 2'b10, cc: 2'b10, cfg: 2'b10, rr: 2'b10};
    next_cycle();
    expect_channel(RW);
    for (int i = 0; i < 4; i++) begin
      send_packet(order[i], pkt_len(), 1'b0);
      next_cycle();
      exp = (i < 3) ? order[i + 1] : RW;
      expect_channel(exp);
    end
  endtask

  task automatic back_pressure();
    int gap;
    gap = 1 + rand_bits(3);  // 1 to 8 stalled cycles
    drive_beat(RR, 1'b1, 1'b0);
    next_cycle();
    expect_channel(RR);
    tx_ready = 1'b0;
    drive_beat(RR, 1'b1, 1'b1);  // Last beat stuck at the sink
    repeat (gap) begin
      next_cycle();
      expect_channel(RR);
    end
    tx_ready = 1'b1;
    next_cycle();
    expect_channel(RR);  // Completion cycle
    drive_beat(RR, 1'b0, 1'b0);
    next_cycle();
    expect_channel(RW);
  endtask

  task automatic queued_rw();
    drive_beat(CC, 1'b1, 1'b0);
    drive_beat(RR, 1'b1, 1'b0);
    next_cycle();
    expect_channel(CC);
    drive_beat(RW, 1'b1, 1'b0);  // Lands in the FIFO while the PSR is busy
    next_cycle();
    expect_channel(CC);
    send_packet(CC, pkt_len(), 1'b0);
    next_cycle();
    expect_channel(RR);  // RW waits behind the PSR
    send_packet(RR, pkt_len(), 1'b0);
    next_cycle();
    expect_channel(RW);  // Reloaded from the FIFO head
    send_packet(RW, pkt_len(), 1'b0);
    next_cycle();
    expect_channel(RW);
    check_val("thrtl", 32'(thrtl), 32'(0));
  endtask

  task automatic b2b_throttle();
    thrtl_t rw_only;
    rw_only    = '0;
    rw_only.rw = 1'b1;
    drive_beat(RW, 1'b1, 1'b0);
    drive_beat(CC, 1'b1, 1'b0);
    next_cycle();
    expect_channel(RW);
    send_packet(RW, pkt_len(), 1'b1);  // RW valid stays up past its last beat
    #1;
    check_val("thrtl", 32'(thrtl), 32'(rw_only));  // CC still pending
    next_cycle();
    expect_channel(CC);
    check_val("thrtl", 32'(thrtl), 32'(0));
    send_packet(CC, pkt_len(), 1'b0);
    next_cycle();
    expect_channel(RW);  // Second RW packet from the FIFO
    send_packet(RW, pkt_len(), 1'b0);
    next_cycle();
    expect_channel(RW);
  endtask

  task automatic link_loss();
    drive_beat(CC, 1'b1, 1'b0);
    next_cycle();
    expect_channel(CC);
    drive_beat(RR, 1'b1, 1'b0);  // Queued behind CC
    next_cycle();
    expect_channel(CC);
    link_up = 1'b0;
    beats   = '0;
    wait_sel(RW, 4);
    repeat (3) begin
      next_cycle();
      expect_channel(RW);  // Nothing comes back while down
    end
    link_up = 1'b1;
    drive_beat(CFG, 1'b1, 1'b0);
    next_cycle();
    expect_channel(CFG);
    send_packet(CFG, pkt_len(), 1'b0);
    next_cycle();
    expect_channel(RW);  // RR entry was flushed
    // CC completes on a dead link and drops the pending CFG request
    drive_beat(CC, 1'b1, 1'b0);
    drive_beat(CFG, 1'b1, 1'b0);
    next_cycle();
    expect_channel(CC);
    link_up = 1'b0;  // CFG valid stays high from here on
    next_cycle();
    expect_channel(CC);
    send_packet(CC, pkt_len(), 1'b0);
    next_cycle();
    expect_channel(RW);   // PSR cleared with CFG still in it
    link_up = 1'b1;
    next_cycle();
    expect_channel(CFG);  // Raised again from the held valid
    send_packet(CFG, pkt_len(), 1'b0);
    next_cycle();
    expect_channel(RW);
  endtask

  initial begin
    com_sysrst = 1'b1;
    beats      = '0;
    tx_ready   = 1'b1;
    link_up    = 1'b1;
    lfsr_state = 32'hcadcbcf5;
    repeat (8) @(posedge com_iclk);
    #2;
    com_sysrst = 1'b0;

    reset_state();
    single_request(CFG);
    single_request(CC);
    single_request(RR);
    all_at_once();
    back_pressure();
    queued_rw();
    b2b_throttle();
    link_loss();
    next_cycle();

    if (DUT.u_pkt_scheduler.u_props.err_fifo_full ||
        DUT.u_pkt_scheduler.u_props.err_double_done ||
        DUT.u_pkt_scheduler.u_props.err_sel_moved) begin
      fail_stop("Scheduler assertion failed during the run");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

/* tb/tx_arbiter_properties.sv */
// Scheduler checks on FIFO fill, completion pulse width and select stability under back-pressure
`timescale 1ns/10ps

module tx_arbiter_properties #(
  parameter int DEPTH = arb_pkg::DEF_FIFO_DEPTH
) (
  input logic               com_iclk,
  input logic               com_sysrst,
  input logic               tx_ready,
  input logic               link_up,
  input logic               completed,
  input logic               psr_idle,
  input arb_pkg::chan_sel_e channel_sel,
  input logic               push,
  input logic               pop
);

  int   occupancy;               // Entries in the request FIFO
  logic err_fifo_full   = 1'b0;  // Sticky flag per assertion
  logic err_double_done = 1'b0;
  logic err_sel_moved   = 1'b0;

  // Fill level follows push and pop and a dead link empties the queue
  always_ff @(posedge com_iclk) begin
    if (com_sysrst || !link_up) begin
      occupancy <= 0;
    end else begin
      occupancy <= occupancy + (push ? 1 : 0) - (pop ? 1 : 0);
    end
  end

  // One slot stays free, so DEPTH-1 entries is full
  a_no_push_full: assert property (@(posedge com_iclk) disable iff (com_sysrst)
    (link_up && push && !pop) |-> (occupancy < DEPTH - 1))
    else begin
      err_fifo_full = 1'b1;
      $error("Push into a full request FIFO");
    end

  a_single_done: assert property (@(posedge com_iclk) disable iff (com_sysrst)
    completed |=> !completed)
    else begin
      err_double_done = 1'b1;
      $error("Completion pulse longer than one cycle");
    end

  // A stalled beat never completes and the busy PSR keeps its channel
  a_sel_hold: assert property (@(posedge com_iclk) disable iff (com_sysrst)
    (!tx_ready && !completed && !psr_idle && link_up) |=>
      (!completed && $stable(channel_sel)))
    else begin
      err_sel_moved = 1'b1;
      $error("channel_sel moved or a packet completed while tx_ready was low");
    end

endmodule
